//--- rtl/pdp8_defs.svh
`ifndef PDP8_DEFS_SVH
`define PDP8_DEFS_SVH

// highest installed memory field
`define PDP8_MAX_FIELD 1

// two fields of 4096 words
`define PDP8_MEM_WORDS 8192

// upper address bits of locations 0010 to 0017
`define PDP8_AUTO_INDEX_PAGE 9'o001

`endif

//--- rtl/pdp8_types_pkg.sv
`default_nettype none

package pdp8_types_pkg;

    // bit 0 is the most significant, as in the PDP-8 manuals
    typedef logic [0:11] word_t;

    typedef logic [0:4] page_t;     // address bits 0..4

    typedef logic [0:6] offset_t;   // address bits 5..11

    typedef logic [0:2] field_t;

    // low field bit followed by the 12-bit word address
    typedef logic [0:12] mem_addr_t;

endpackage

`default_nettype wire

//--- rtl/pdp8_ctrl_pkg.sv
`default_nettype none

package pdp8_ctrl_pkg;

    // five clocks per major cycle
    typedef enum logic [4:0] {
        F0, FW, F1, F2, F3,     // fetch
        D0, DW, D1, D2, D3,     // defer
        E0, EW, E1, E2, E3,     // execute
        H0, HW, H1, H2, H3      // halt and panel
    } major_state_t;

    // instruction bits 0..2
    typedef enum logic [2:0] {
        AND = 3'o0,
        TAD = 3'o1,
        ISZ = 3'o2,
        DCA = 3'o3,
        JMS = 3'o4,
        JMP = 3'o5,
        IOT = 3'o6,
        OPR = 3'o7
    } opcode_t;

endpackage

`default_nettype wire

//--- rtl/core_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "pdp8_defs.svh"

module core_memory
    import pdp8_types_pkg::*;
(
    input  wire  clk,
    input  wire  mem_addr_t addr,
    input  wire  word_t wdata,
    input  wire  we,
    output word_t rdata
);

    word_t mem [`PDP8_MEM_WORDS];   // program and data

    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
    end

    // read is combinational, sampled by the caller
    assign rdata = mem[addr];

endmodule

`default_nettype wire

//--- rtl/memory_address_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "pdp8_defs.svh"

module memory_address_unit
    import pdp8_types_pkg::*;
    import pdp8_ctrl_pkg::*;
(
    input  wire  clk,
    input  wire  reset,
    input  wire  major_state_t state,
    input  wire  word_t pc,
    input  wire  word_t ac,
    input  wire  word_t sr,
    input  wire  field_t if_field,
    input  wire  field_t df_field,
    input  wire  load_addr_d,
    input  wire  deposit_d,
    input  wire  examine_d,
    output word_t ma,
    output word_t mb,
    output word_t instruction,
    output logic isz_skip
);

    word_t     addr;
    field_t    ema;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;
    word_t     rd_word;
    logic      mem_we;
    logic      field_ok;
    logic      mem_ref;
    logic      defer_mref;
    logic      auto_index;
    page_t     current_page;
    opcode_t   opcode;

    assign opcode     = opcode_t'(instruction[0:2]);
    assign mem_ref    = (opcode != IOT) && (opcode != OPR);
    assign defer_mref = mem_ref && instruction[3];
    assign auto_index = (ma[0:8] == `PDP8_AUTO_INDEX_PAGE);

    // address and field select
    always_comb
    begin
        case (state)
            F0, FW: addr = pc;
            default: addr = ma;
        endcase
        case (state)
            D0, DW, D1, D2, D3, E0, EW, E1, E2, E3:
                ema = defer_mref ? df_field : if_field;
            default:
                ema = if_field;
        endcase
    end

    assign field_ok = (ema <= `PDP8_MAX_FIELD);
    assign mem_addr = {ema[2], addr};
    assign rd_word  = field_ok ? mem_rdata : 12'o0000;   // missing field reads zero

    core_memory i_core_memory (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

    always_ff @(posedge clk)
    begin
        case (state)
            FW:
            begin
                mb <= rd_word;
                current_page <= pc[0:4];    // pc not yet incremented
            end
            DW, EW, HW: mb <= rd_word;
            D1: mem_wdata <= mb + 12'o0001;
            E1:
                case (opcode)
                    ISZ: mem_wdata <= mb + 12'o0001;
                    DCA: mem_wdata <= ac;
                    JMS: mem_wdata <= pc;   // return address
                    default: ;
                endcase
            H1: mem_wdata <= sr;
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ma <= 12'o0000;
            instruction <= 12'o7000;
            isz_skip <= 1'b0;
            mem_we <= 1'b0;
        end
        else
        begin
            mem_we <= 1'b0;    // writes last one clock
            case (state)
                FW: instruction <= rd_word;
                F3:
                    if (mem_ref)
                        ma <= {(instruction[4] ? current_page : page_t'(0)),
                               offset_t'(instruction[5:11])};
                D1:
                    if (auto_index)
                        mem_we <= field_ok;
                D2:
                    if (auto_index)
                        ma <= mb + 12'o0001;
                    else
                        ma <= mb;
                E1:
                    case (opcode)
                        ISZ:
                        begin
                            mem_we <= field_ok;
                            if (mb == 12'o7777)
                                isz_skip <= 1'b1;
                        end
                        DCA, JMS: mem_we <= field_ok;
                        default: ;
                    endcase
                E3: isz_skip <= 1'b0;
                H1:
                    if (load_addr_d)
                        ma <= sr;
                    else if (deposit_d)
                        mem_we <= field_ok;
                H2:
                    if (deposit_d || examine_d)
                        ma <= ma + 12'o0001;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/major_state_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module major_state_sequencer
    import pdp8_types_pkg::*;
    import pdp8_ctrl_pkg::*;
(
    input  wire  clk,
    input  wire  reset,
    input  wire  word_t instruction,
    input  wire  load_addr,
    input  wire  deposit,
    input  wire  examine,
    input  wire  run,
    output major_state_t state,
    output logic halted,
    output logic load_addr_d,
    output logic deposit_d,
    output logic examine_d
);

    opcode_t opcode;
    logic    mem_ref;
    logic    hlt;
    logic    panel_req;

    assign opcode    = opcode_t'(instruction[0:2]);
    assign mem_ref   = (opcode != IOT) && (opcode != OPR);
    // group 2 operate with the HLT bit
    assign hlt       = (opcode == OPR) && instruction[3] && !instruction[11] && instruction[10];
    assign panel_req = load_addr || deposit || examine;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= H3;
            halted <= 1'b1;
            load_addr_d <= 1'b0;
            deposit_d <= 1'b0;
            examine_d <= 1'b0;
        end
        else
        begin
            case (state)
                F0: state <= FW;
                FW: state <= F1;
                F1: state <= F2;
                F2: state <= F3;
                F3:
                    if (mem_ref)
                        state <= instruction[3] ? D0 : E0;
                    else if (hlt)
                    begin
                        state <= H0;
                        halted <= 1'b1;
                    end
                    else
                        state <= F0;
                D0: state <= DW;
                DW: state <= D1;
                D1: state <= D2;
                D2: state <= D3;
                D3: state <= E0;
                E0: state <= EW;
                EW: state <= E1;
                E1: state <= E2;
                E2: state <= E3;
                E3: state <= F0;
                H0: state <= HW;
                HW: state <= H1;
                H1: state <= H2;
                H2: state <= H3;
                H3:
                begin
                    // one request at a time, held for the whole halt cycle
                    load_addr_d <= load_addr && !run;
                    deposit_d <= deposit && !run && !load_addr;
                    examine_d <= examine && !run && !load_addr && !deposit;
                    if (halted && run)
                    begin
                        state <= F0;
                        halted <= 1'b0;
                    end
                    else if (halted && panel_req)
                        state <= H0;
                end
                default: state <= H3;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/register_unit.sv
`timescale 1ns/1ns
`default_nettype none

module register_unit
    import pdp8_types_pkg::*;
    import pdp8_ctrl_pkg::*;
(
    input  wire  clk,
    input  wire  reset,
    input  wire  major_state_t state,
    input  wire  word_t instruction,
    input  wire  word_t mb,
    input  wire  word_t ma,
    input  wire  isz_skip,
    input  wire  word_t sr,
    input  wire  load_addr_d,
    output word_t pc,
    output word_t ac,
    output logic link
);

    opcode_t     opcode;
    word_t       opr_ac;
    logic        opr_link;
    logic [0:12] tad_sum;   // carry, then sum

    assign opcode  = opcode_t'(instruction[0:2]);
    assign tad_sum = {1'b0, ac} + {1'b0, mb};

    // operate subset in microcode order
    always_comb
    begin
        opr_ac = ac;
        opr_link = link;
        if (instruction[4])
            opr_ac = 12'o0000;      // CLA
        if (!instruction[3])
        begin
            if (instruction[6])
                opr_ac = ~opr_ac;   // CMA
            if (instruction[11])
                {opr_link, opr_ac} = {opr_link, opr_ac} + 13'd1;   // IAC
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= 12'o0000;
            ac <= 12'o0000;
            link <= 1'b0;
        end
        else
        begin
            case (state)
                F2: pc <= pc + 12'o0001;
                F3:
                    if (opcode == OPR)
                    begin
                        ac <= opr_ac;
                        link <= opr_link;
                    end
                E2:
                    case (opcode)
                        AND: ac <= ac & mb;
                        TAD:
                        begin
                            ac <= tad_sum[1:12];
                            link <= link ^ tad_sum[0];
                        end
                        DCA: ac <= 12'o0000;
                        default: ;
                    endcase
                E3:
                    case (opcode)
                        JMP: pc <= ma;
                        JMS: pc <= ma + 12'o0001;   // past the stored return
                        ISZ:
                            if (isz_skip)
                                pc <= pc + 12'o0001;
                        default: ;
                    endcase
                H1:
                    if (load_addr_d)
                        pc <= sr;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/pdp8_core.sv
`timescale 1ns/1ns
`default_nettype none

module pdp8_core
    import pdp8_types_pkg::*;
    import pdp8_ctrl_pkg::*;
(
    input  wire  clk,
    input  wire  reset,
    input  wire  word_t sr,
    input  wire  field_t if_field,
    input  wire  field_t df_field,
    input  wire  load_addr,
    input  wire  deposit,
    input  wire  examine,
    input  wire  run,
    output word_t ac,
    output logic link,
    output word_t pc,
    output word_t ma,
    output word_t mb,
    output logic halted
);

    major_state_t state;
    word_t        instruction;
    logic         isz_skip;
    logic         load_addr_d;
    logic         deposit_d;
    logic         examine_d;

    memory_address_unit i_memory_address_unit (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .pc          (pc),
        .ac          (ac),
        .sr          (sr),
        .if_field    (if_field),
        .df_field    (df_field),
        .load_addr_d (load_addr_d),
        .deposit_d   (deposit_d),
        .examine_d   (examine_d),
        .ma          (ma),
        .mb          (mb),
        .instruction (instruction),
        .isz_skip    (isz_skip)
    );

    major_state_sequencer i_major_state_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .load_addr   (load_addr),
        .deposit     (deposit),
        .examine     (examine),
        .run         (run),
        .state       (state),
        .halted      (halted),
        .load_addr_d (load_addr_d),
        .deposit_d   (deposit_d),
        .examine_d   (examine_d)
    );

    register_unit i_register_unit (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .instruction (instruction),
        .mb          (mb),
        .ma          (ma),
        .isz_skip    (isz_skip),
        .sr          (sr),
        .load_addr_d (load_addr_d),
        .pc          (pc),
        .ac          (ac),
        .link        (link)
    );

endmodule

`default_nettype wire

//--- verif/pdp8_core_properties.sv
`timescale 1ns/1ns
`default_nettype none

`include "pdp8_defs.svh"

module pdp8_core_properties
    import pdp8_types_pkg::*;
    import pdp8_ctrl_pkg::*;
(
    input  wire  clk,
    input  wire  reset,
    input  wire  major_state_t state,
    input  wire  field_t ema,
    input  wire  mem_we,
    input  wire  isz_skip
);

    // uninstalled fields are never written
    no_write_outside_fields: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> (ema <= field_t'(`PDP8_MAX_FIELD)))
        else $error("memory write to a field that is not installed");

    single_cycle_write: assert property (@(posedge clk) disable iff (reset)
        mem_we |=> !mem_we)
        else $error("write enable held for two cycles");

    skip_clear_in_fetch: assert property (@(posedge clk) disable iff (reset)
        (state inside {F0, FW, F1, F2, F3}) |-> !isz_skip)
        else $error("isz skip flag still set during fetch");

endmodule

bind memory_address_unit pdp8_core_properties i_pdp8_core_properties (
    .clk      (clk),
    .reset    (reset),
    .state    (state),
    .ema      (ema),
    .mem_we   (mem_we),
    .isz_skip (isz_skip)
);

`default_nettype wire

//--- verif/pdp8_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "pdp8_defs.svh"

module pdp8_core_tb
    import pdp8_types_pkg::*;
;

    localparam int clk_period = 40;
    localparam int watchdog_cycles = 5000;  // all tests need well under 2500 clocks

    logic   clk;
    logic   reset;
    word_t  sr;
    field_t if_field;
    field_t df_field;
    logic   load_addr;
    logic   deposit;
    logic   examine;
    logic   run;
    word_t  ac;
    logic   link;
    word_t  pc;
    word_t  ma;
    word_t  mb;
    logic   halted;

    word_t  model_mem [`PDP8_MEM_WORDS];
    word_t  m_ac;
    logic   m_link;
    word_t  m_pc;
    word_t  panel_ma;       // where ma should point
    word_t  prog [$];
    int     error_count;

    pdp8_core i_pdp8_core (
        .clk       (clk),
        .reset     (reset),
        .sr        (sr),
        .if_field  (if_field),
        .df_field  (df_field),
        .load_addr (load_addr),
        .deposit   (deposit),
        .examine   (examine),
        .run       (run),
        .ac        (ac),
        .link      (link),
        .pc        (pc),
        .ma        (ma),
        .mb        (mb),
        .halted    (halted)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_on_failure();
        error_count++;
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic value_error(input string what, input word_t got, input word_t exp);
        $display("** Error: %0t ns: %s is %o, expected %o", $time, what, got, exp);
        stop_on_failure();
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else value_error(what, got, exp);
    endtask

    function automatic word_t model_read(input field_t fld, input word_t a);
        if (fld > field_t'(`PDP8_MAX_FIELD))
            return 12'o0000;    // missing field
        return model_mem[{fld[2], a}];
    endfunction

    task automatic model_write(input field_t fld, input word_t a, input word_t d);
        if (fld <= field_t'(`PDP8_MAX_FIELD))
            model_mem[{fld[2], a}] = d;
    endtask

    // instruction level model, runs to HLT
    task automatic model_run(input word_t start);
        word_t       cur;
        word_t       ir;
        word_t       ea;
        word_t       opnd;
        field_t      fld;
        logic [0:12] sum;
        int          steps;
        logic        done;
        cur = start;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 200)
        begin
            ir = model_read(if_field, cur);
            ea = {(ir[4] ? cur[0:4] : 5'b00000), ir[5:11]};
            cur = cur + 12'o0001;
            steps++;
            if (ir[0:2] == 3'o7)
            begin
                if (!ir[3])
                begin
                    if (ir[4])
                        m_ac = 12'o0000;
                    if (ir[6])
                        m_ac = ~m_ac;
                    if (ir[11])
                        {m_link, m_ac} = {m_link, m_ac} + 13'd1;
                end
                else if (ir[10] && !ir[11])
                    done = 1'b1;    // HLT
            end
            else if (ir[0:2] != 3'o6)
            begin
                fld = ir[3] ? df_field : if_field;
                if (ir[3])
                begin
                    opnd = model_read(fld, ea);
                    if (ea[0:8] == `PDP8_AUTO_INDEX_PAGE)
                    begin
                        opnd = opnd + 12'o0001;
                        model_write(fld, ea, opnd);
                    end
                    ea = opnd;
                end
                opnd = model_read(fld, ea);
                case (ir[0:2])
                    3'o0: m_ac = m_ac & opnd;
                    3'o1:
                    begin
                        sum = {1'b0, m_ac} + {1'b0, opnd};
                        m_ac = sum[1:12];
                        m_link = m_link ^ sum[0];
                    end
                    3'o2:
                    begin
                        opnd = opnd + 12'o0001;
                        model_write(fld, ea, opnd);
                        if (opnd == 12'o0000)
                            cur = cur + 12'o0001;
                    end
                    3'o3:
                    begin
                        model_write(fld, ea, m_ac);
                        m_ac = 12'o0000;
                    end
                    3'o4:
                    begin
                        model_write(fld, ea, cur);
                        cur = ea + 12'o0001;
                    end
                    default: cur = ea;  // JMP
                endcase
            end
        end
        m_pc = cur;
    endtask

    task automatic do_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        m_ac = 12'o0000;
        m_link = 1'b0;
    endtask

    task automatic set_fields(input field_t ifld, input field_t dfld);
        @(posedge clk);
        if_field <= ifld;
        df_field <= dfld;
    endtask

    task automatic panel_load(input word_t a);
        @(posedge clk);
        sr <= a;
        load_addr <= 1'b1;
        @(posedge clk);
        load_addr <= 1'b0;
        repeat (8) @(posedge clk);
        panel_ma = a;
    endtask

    task automatic panel_deposit(input word_t d);
        @(posedge clk);
        sr <= d;
        deposit <= 1'b1;
        @(posedge clk);
        deposit <= 1'b0;
        repeat (8) @(posedge clk);
        model_write(if_field, panel_ma, d);
        panel_ma = panel_ma + 12'o0001;
    endtask

    task automatic panel_examine(output word_t d);
        @(posedge clk);
        examine <= 1'b1;
        @(posedge clk);
        examine <= 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        d = mb;
        panel_ma = panel_ma + 12'o0001;
    endtask

    task automatic load_block(input word_t start);
        panel_load(start);
        foreach (prog[i])
            panel_deposit(prog[i]);
    endtask

    task automatic run_until_halt(input int max_cycles);
        int n;
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
        assert (!halted) else
        begin
            $display("run pulse did not start the processor");
            stop_on_failure();
        end
        n = 0;
        while (!halted && n < max_cycles)
        begin
            @(negedge clk);
            n++;
        end
        assert (halted) else
        begin
            $display("processor did not halt within %0d cycles", max_cycles);
            stop_on_failure();
        end
        repeat (6) @(posedge clk);  // rest of the halt cycle
        @(negedge clk);
    endtask

    // model first, then the DUT
    task automatic execute(input word_t start);
        panel_load(start);
        model_run(start);
        run_until_halt(500);
        check_word("ac", ac, m_ac);
        check_word("link", word_t'(link), word_t'(m_link));
        check_word("halt pc", pc, m_pc);
    endtask

    task automatic test_reset();
        do_reset();
        @(negedge clk);
        check_word("halted after reset", word_t'(halted), 12'o0001);
        check_word("ac after reset", ac, 12'o0000);
        check_word("pc after reset", pc, 12'o0000);
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_word("halted without run", word_t'(halted), 12'o0001);
        check_word("pc without run", pc, 12'o0000);
    endtask

    task automatic test_deposit_examine();
        word_t f0_data [4];
        word_t f1_data [4];
        word_t d;
        foreach (f0_data[i])
        begin
            f0_data[i] = word_t'($urandom);
            f1_data[i] = word_t'($urandom);
        end
        set_fields(3'd0, 3'd0);
        prog = {f0_data[0], f0_data[1], f0_data[2], f0_data[3]};
        load_block(12'o0200);
        check_word("ma after deposits", ma, 12'o0204);
        set_fields(3'd1, 3'd0);
        prog = {f1_data[0], f1_data[1], f1_data[2], f1_data[3]};
        load_block(12'o0200);
        set_fields(3'd0, 3'd0);
        panel_load(12'o0200);
        foreach (f0_data[i])
        begin
            panel_examine(d);
            check_word("field 0 examine", d, f0_data[i]);
            check_word("ma after examine", ma, panel_ma);
        end
        set_fields(3'd1, 3'd0);
        panel_load(12'o0200);
        foreach (f1_data[i])
        begin
            panel_examine(d);
            check_word("field 1 examine", d, f1_data[i]);
        end
        set_fields(3'd5, 3'd0);
        prog = {12'o5252};
        load_block(12'o0200);   // no such field, dropped
        panel_load(12'o0200);
        panel_examine(d);
        check_word("field 5 examine", d, 12'o0000);
        // field 5 shares its low bit with field 1
        set_fields(3'd1, 3'd0);
        panel_load(12'o0200);
        panel_examine(d);
        check_word("field 1 after field 5 deposit", d, f1_data[0]);
    endtask

    task automatic test_program();
        word_t d;
        set_fields(3'd0, 3'd0);
        prog = {12'o7200, 12'o1210, 12'o0211, 12'o1212, 12'o3213, 12'o7402,
                12'o0000, 12'o0000, word_t'($urandom), word_t'($urandom),
                word_t'($urandom), 12'o0000};
        load_block(12'o0200);
        execute(12'o0200);
        check_word("ac after dca", ac, 12'o0000);
        panel_load(12'o0213);
        panel_examine(d);
        check_word("dca target", d, model_read(3'd0, 12'o0213));
    endtask

    task automatic test_control_flow();
        word_t v;
        word_t d;
        v = word_t'($urandom_range(0, 12'o7776));
        set_fields(3'd0, 3'd0);
        prog = {12'o7200, 12'o2240, 12'o7402, 12'o2241, 12'o7001, 12'o4250, 12'o7402};
        load_block(12'o0400);
        prog = {12'o7777, v};
        load_block(12'o0440);
        prog = {12'o0000, 12'o7001, 12'o5650};  // return slot, IAC, JMP I 0450
        load_block(12'o0450);
        execute(12'o0400);
        check_word("halt pc after return", pc, 12'o0407);
        check_word("ac after two iac", ac, 12'o0002);
        panel_load(12'o0440);
        panel_examine(d);
        check_word("isz on 7777", d, 12'o0000);
        panel_examine(d);
        check_word("isz no skip", d, v + 12'o0001);
        panel_load(12'o0450);
        panel_examine(d);
        check_word("jms return address", d, 12'o0406);
    endtask

    task automatic test_indirect();
        word_t x;
        word_t y;
        word_t d;
        x = word_t'($urandom);
        y = word_t'($urandom);
        set_fields(3'd1, 3'd0);
        prog = {12'o0300};
        load_block(12'o0020);
        prog = {x};
        load_block(12'o0300);
        set_fields(3'd0, 3'd0);
        prog = {12'o0301};      // decoy pointer in field 0
        load_block(12'o0020);
        prog = {~x};
        load_block(12'o0301);
        prog = {12'o7200, 12'o1420, 12'o7402};
        load_block(12'o0600);
        set_fields(3'd0, 3'd1);
        execute(12'o0600);
        check_word("indirect tad from field 1", ac, x);
        set_fields(3'd0, 3'd0);
        prog = {12'o0317};
        load_block(12'o0010);
        prog = {y};
        load_block(12'o0320);
        prog = {12'o7200, 12'o1410, 12'o7040, 12'o7001, 12'o7402};
        load_block(12'o0700);
        execute(12'o0700);
        check_word("cma iac", ac, 12'o0000 - y);
        panel_load(12'o0010);
        panel_examine(d);
        check_word("auto-index location", d, 12'o0320);
    endtask

    // watchdog
    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("watchdog timeout, simulation ran too long");
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    initial
    begin
        clk = 1'b0;
        reset <= 1'b1;
        sr <= 12'o0000;
        if_field <= 3'd0;
        df_field <= 3'd0;
        load_addr <= 1'b0;
        deposit <= 1'b0;
        examine <= 1'b0;
        run <= 1'b0;
        error_count = 0;
        panel_ma = 12'o0000;
        void'($urandom(32'h61752717));
        foreach (model_mem[i])
            model_mem[i] = 12'o0000;
        test_reset();
        test_deposit_examine();
        do_reset();
        test_program();
        do_reset();
        test_control_flow();
        do_reset();
        test_indirect();
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
rtl/pdp8_types_pkg.sv
rtl/pdp8_ctrl_pkg.sv
rtl/core_memory.sv
rtl/memory_address_unit.sv
rtl/major_state_sequencer.sv
rtl/register_unit.sv
rtl/pdp8_core.sv
verif/pdp8_core_properties.sv
verif/pdp8_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = pdp8_core_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
